//--- logic/video_pkg.sv
// video path types and luma weights shared by capture, gray and test model
package video_pkg;

    // rgb565 colour fields, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // byte view of the same word
    typedef struct packed {
        logic [7:0] hi;    // first byte on the bus
        logic [7:0] lo;    // second byte
    } cam_bytes_t;

    // one camera word, filled by bytes and read as colour
    typedef union packed {
        rgb565_t    rgb;
        cam_bytes_t bytes;
    } cam_word_u;

    // capture stage output beat, 18 bits
    typedef struct packed {
        logic      valid;    // one cycle per pixel
        logic      sol;      // first pixel after href rise
        cam_word_u word;
    } cam_pix_t;

    // gray stage output beat, 10 bits
    typedef struct packed {
        logic       valid;
        logic       sol;
        logic [7:0] gray;
    } gray_pix_t;

    // luma weights, sum is 256 so the result is taken from bits 15:8
    localparam logic [7:0] GRAY_R_W = 8'd77;
    localparam logic [7:0] GRAY_G_W = 8'd150;
    localparam logic [7:0] GRAY_B_W = 8'd29;

endpackage

//--- logic/cam_capture.sv
// camera byte capture, pairs bytes into rgb565 words while href is high
`timescale 1ns/1ps

module cam_capture import video_pkg::*; (
    input  logic       vtc_vs_out,
    input  logic       i_reset,
    input  logic       i_cam_href,     // line valid level
    input  logic       i_cam_vsync,    // bytes ignored while high
    input  logic [7:0] i_cam_data,
    output cam_pix_t   o_pix
);

    logic       href_q;     // sampled camera controls
    logic       vsync_q;
    logic [7:0] data_q;     // sampled camera byte
    logic       byte_ok;    // sampled byte belongs to a line
    logic       byte_ph;    // 0 = expecting high byte
    logic       first_pix;  // next pixel opens the line
    logic       pix_valid;
    logic       pix_sol;
    cam_word_u  pix_word;

    assign byte_ok = href_q & ~vsync_q;

    // input sampling stage, pixel logic works one cycle behind the pins
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            href_q  <= i_cam_href;
            vsync_q <= i_cam_vsync;
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        data_q <= i_cam_data;
    end

    // byte phase and pixel strobe
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            byte_ph   <= 1'b0;
            first_pix <= 1'b1;
            pix_valid <= 1'b0;
            pix_sol   <= 1'b0;
        end else begin
            pix_valid <= 1'b0;    // strobe, one cycle only
            pix_sol   <= 1'b0;
            if (!href_q) begin
                byte_ph   <= 1'b0;    // phase restarts between lines, odd byte lost
                first_pix <= 1'b1;
            end else if (byte_ok) begin
                byte_ph <= ~byte_ph;
                if (byte_ph) begin    // low byte completes the pair
                    pix_valid <= 1'b1;
                    pix_sol   <= first_pix;
                    first_pix <= 1'b0;
                end
            end
        end
    end

    // word assembly in the byte view
    always_ff @(posedge vtc_vs_out) begin
        if (byte_ok) begin
            if (!byte_ph) pix_word.bytes.hi <= data_q;
            else          pix_word.bytes.lo <= data_q;
        end
    end

    assign o_pix = '{valid: pix_valid, sol: pix_sol, word: pix_word};

endmodule

//--- logic/gray_convert.sv
// rgb565 to 8-bit gray, channel widening and weighted luma sum, one register stage
`timescale 1ns/1ps

module gray_convert import video_pkg::*; (
    input  logic      vtc_vs_out,
    input  logic      i_reset,
    input  cam_pix_t  i_pix,
    output gray_pix_t o_gray
);

    logic [7:0]  red8;        // channels widened to 8 bits
    logic [7:0]  grn8;
    logic [7:0]  blu8;
    logic [15:0] luma_sum;    // max 255 * 256, fits
    logic        gray_valid;
    logic        gray_sol;
    logic [7:0]  gray_q;

    // top bits repeated into the empty lsbs so full scale maps to 8'hff
    assign red8 = {i_pix.word.rgb.red, i_pix.word.rgb.red[4:2]};
    assign grn8 = {i_pix.word.rgb.green, i_pix.word.rgb.green[5:4]};
    assign blu8 = {i_pix.word.rgb.blue, i_pix.word.rgb.blue[4:2]};

    assign luma_sum = 16'(red8) * 16'(GRAY_R_W)
                    + 16'(grn8) * 16'(GRAY_G_W)
                    + 16'(blu8) * 16'(GRAY_B_W);

    // strobes ride along with the data
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            gray_valid <= 1'b0;
            gray_sol   <= 1'b0;
        end else begin
            gray_valid <= i_pix.valid;
            gray_sol   <= i_pix.sol;
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        gray_q <= luma_sum[15:8];    // >> 8
    end

    assign o_gray = '{valid: gray_valid, sol: gray_sol, gray: gray_q};

endmodule

//--- logic/line_buffer.sv
// one-line gray RAM, written by column from the gray stage, read on display request
`timescale 1ns/1ps

module line_buffer import video_pkg::*; #(
    parameter int H_DISP  = 640,
    parameter int LINE_AW = 10
) (
    input  logic               vtc_vs_out,
    input  logic               i_reset,
    input  gray_pix_t          i_wr,
    input  logic               i_rd_req,
    input  logic [LINE_AW-1:0] i_rd_col,
    output logic [7:0]         o_rd_gray
);

    logic [7:0]   line_mem [0:(1<<LINE_AW)-1];
    logic [LINE_AW:0] wr_col;      // one extra bit so it can sit at H_DISP
    logic [LINE_AW:0] beat_col;    // column of the current beat
    logic         wr_en;
    logic [7:0]   rd_q;

    assign beat_col = i_wr.sol ? '0 : wr_col;    // sol restarts at column 0
    assign wr_en    = i_wr.valid && (beat_col < (LINE_AW+1)'(H_DISP));

    // write column, parks at H_DISP until the next sol
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            wr_col <= '0;
        end else if (wr_en) begin
            wr_col <= beat_col + 1'b1;
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        if (wr_en) line_mem[beat_col[LINE_AW-1:0]] <= i_wr.gray;
    end

    // read port, data one cycle after request
    always_ff @(posedge vtc_vs_out) begin
        if (i_rd_req) rd_q <= line_mem[i_rd_col];
    end

    assign o_rd_gray = rd_q;

endmodule

//--- logic/video_timing.sv
// display raster timing, line buffer read request, gray output and frame LED
`timescale 1ns/1ps

module video_timing #(
    parameter int H_DISP  = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_DISP  = 480,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33,
    parameter int LINE_AW = 10
) (
    input  logic               vtc_vs_out,
    input  logic               i_reset,
    input  logic [7:0]         i_rd_gray,
    output logic               o_rd_req,
    output logic [LINE_AW-1:0] o_rd_col,
    output logic               o_hs,
    output logic               o_vs,
    output logic               o_de,
    output logic [7:0]         o_gray,
    output logic               o_frame_led
);

    localparam int H_TOTAL = H_DISP + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_DISP + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;      // pixel within line, active first
    logic [VW-1:0] v_cnt;      // line within frame
    logic          h_last;
    logic          v_last;
    logic          act;        // counters sit on an active pixel
    logic          hs_next;
    logic          vs_next;
    logic          de_q;
    logic          hs_q;
    logic          vs_q;
    logic [4:0]    frame_cnt;  // vs pulses since reset

    assign h_last = (h_cnt == HW'(H_TOTAL - 1));
    assign v_last = (v_cnt == VW'(V_TOTAL - 1));

    // raster counters: active, front porch, sync, back porch
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign act     = (h_cnt < HW'(H_DISP)) && (v_cnt < VW'(V_DISP));
    assign hs_next = (h_cnt >= HW'(H_DISP + H_FRONT))
                  && (h_cnt < HW'(H_DISP + H_FRONT + H_SYNC));
    assign vs_next = (v_cnt >= VW'(V_DISP + V_FRONT))
                  && (v_cnt < VW'(V_DISP + V_FRONT + V_SYNC));

    // request leads the displayed pixel by one cycle, RAM latency fills the gap
    assign o_rd_req = act;
    assign o_rd_col = LINE_AW'(h_cnt);

    // syncs delayed by the same cycle as de so all stay aligned
    always_ff @(posedge vtc_vs_out) begin
        if (i_reset) begin
            de_q      <= 1'b0;
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            frame_cnt <= '0;
        end else begin
            de_q <= act;
            hs_q <= hs_next;
            vs_q <= vs_next;
            if (vs_next && !vs_q) frame_cnt <= frame_cnt + 1'b1;    // vs rising
        end
    end

    assign o_de        = de_q;
    assign o_hs        = hs_q;
    assign o_vs        = vs_q;
    assign o_gray      = de_q ? i_rd_gray : 8'h00;    // black in blanking
    assign o_frame_led = frame_cnt[4];                // toggles every 16 frames

endmodule

//--- logic/gray_video_top.sv
// camera to gray display path, capture, gray, line buffer and raster timing
`timescale 1ns/1ps

module gray_video_top import video_pkg::*; #(
    parameter int H_DISP  = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_DISP  = 480,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33,
    parameter int LINE_AW = 10     // must cover H_DISP
) (
    input  logic       vtc_vs_out,
    input  logic       i_reset,
    input  logic       i_cam_href,
    input  logic       i_cam_vsync,
    input  logic [7:0] i_cam_data,
    output logic       o_hs,
    output logic       o_vs,
    output logic       o_de,
    output logic [7:0] o_gray,
    output logic       o_frame_led
);

    cam_pix_t           cam_pix;     // capture -> gray
    gray_pix_t          gray_pix;    // gray -> line buffer
    logic               rd_req;
    logic [LINE_AW-1:0] rd_col;
    logic [7:0]         rd_gray;

    cam_capture cam_capture_i (
        .vtc_vs_out  (vtc_vs_out),
        .i_reset     (i_reset),
        .i_cam_href  (i_cam_href),
        .i_cam_vsync (i_cam_vsync),
        .i_cam_data  (i_cam_data),
        .o_pix       (cam_pix)
    );

    gray_convert gray_convert_i (
        .vtc_vs_out (vtc_vs_out),
        .i_reset    (i_reset),
        .i_pix      (cam_pix),
        .o_gray     (gray_pix)
    );

    line_buffer #(
        .H_DISP  (H_DISP),
        .LINE_AW (LINE_AW)
    ) line_buffer_i (
        .vtc_vs_out (vtc_vs_out),
        .i_reset    (i_reset),
        .i_wr       (gray_pix),
        .i_rd_req   (rd_req),
        .i_rd_col   (rd_col),
        .o_rd_gray  (rd_gray)
    );

    video_timing #(
        .H_DISP  (H_DISP),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_DISP  (V_DISP),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .LINE_AW (LINE_AW)
    ) video_timing_i (
        .vtc_vs_out  (vtc_vs_out),
        .i_reset     (i_reset),
        .i_rd_gray   (rd_gray),
        .o_rd_req    (rd_req),
        .o_rd_col    (rd_col),
        .o_hs        (o_hs),
        .o_vs        (o_vs),
        .o_de        (o_de),
        .o_gray      (o_gray),
        .o_frame_led (o_frame_led)
    );

endmodule

//--- tb/gray_video_sva.sv
// raster checks on the display timing, bound into video_timing
`timescale 1ns/1ps

module gray_video_sva #(
    parameter int H_SYNC = 3
) (
    input logic vtc_vs_out,
    input logic i_reset,
    input logic i_rd_req,
    input logic i_hs,
    input logic i_vs,
    input logic i_de
);

    logic [7:0] hs_len;    // length of the current hs run

    always_ff @(posedge vtc_vs_out) begin
        if (i_reset)   hs_len <= '0;
        else if (i_hs) hs_len <= hs_len + 1'b1;
        else           hs_len <= '0;
    end

    // no picture during sync
    a_de_blank: assert property (@(posedge vtc_vs_out) disable iff (i_reset)
        !(i_de && (i_hs || i_vs)))
        else $error("de high during hs or vs");

    a_hs_width: assert property (@(posedge vtc_vs_out) disable iff (i_reset)
        $fell(i_hs) |-> hs_len == 8'(H_SYNC))
        else $error("hs pulse width wrong");

    // RAM latency is one cycle
    a_req_de: assert property (@(posedge vtc_vs_out) disable iff (i_reset)
        i_rd_req |=> i_de)
        else $error("read request not followed by de");

endmodule

bind video_timing gray_video_sva #(.H_SYNC(H_SYNC)) gray_video_sva_i (
    .vtc_vs_out (vtc_vs_out),
    .i_reset    (i_reset),
    .i_rd_req   (o_rd_req),
    .i_hs       (o_hs),
    .i_vs       (o_vs),
    .i_de       (o_de)
);

//--- tb/gray_video_tb.sv
// testbench for the camera to gray display path, reference gray model and pixel compare
`timescale 1ns/1ps

module gray_video_tb import video_pkg::*; ;

    localparam int H_DISP    = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BACK    = 2;
    localparam int V_DISP    = 4;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 3;
    localparam int V_BACK    = 2;
    localparam int LINE_AW   = 5;
    localparam int FRAME_CYC = (H_DISP + H_FRONT + H_SYNC + H_BACK)
                             * (V_DISP + V_FRONT + V_SYNC + V_BACK);

    logic       vtc_vs_out;
    logic       i_reset;
    logic       i_cam_href;
    logic       i_cam_vsync;
    logic [7:0] i_cam_data;
    logic       o_hs;
    logic       o_vs;
    logic       o_de;
    logic [7:0] o_gray;
    logic       o_frame_led;

    integer     seed;
    logic [7:0] model [0:H_DISP-1];    // expected line contents
    logic       mon_en = 1'b0;         // raster monitor running
    logic       cmp_en = 1'b0;         // model holds a full line
    logic       de_prev = 1'b0;
    logic       vs_prev = 1'b0;
    logic       hs_prev = 1'b0;
    int         col = 0;               // de count within line
    int         line_cnt = 0;          // de lines within frame
    int         vs_cnt = 0;            // vs pulses since reset
    int         since_de = -1;         // cycles since de fell, -1 once hs followed
    int         pix_checked = 0;

    gray_video_top #(
        .H_DISP  (H_DISP),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_DISP  (V_DISP),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .LINE_AW (LINE_AW)
    ) gray_video_top_i (
        .vtc_vs_out  (vtc_vs_out),
        .i_reset     (i_reset),
        .i_cam_href  (i_cam_href),
        .i_cam_vsync (i_cam_vsync),
        .i_cam_data  (i_cam_data),
        .o_hs        (o_hs),
        .o_vs        (o_vs),
        .o_de        (o_de),
        .o_gray      (o_gray),
        .o_frame_led (o_frame_led)
    );

    initial begin
        vtc_vs_out = 1'b0;
        forever #10 vtc_vs_out = ~vtc_vs_out;    // 20 ns
    end

    // widen each field by repeating its top bits, weight, keep the upper byte
    function automatic logic [7:0] ref_gray(input logic [15:0] w);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        int         sum;
        r8  = {w[15:11], w[15:13]};
        g8  = {w[10:5], w[10:9]};
        b8  = {w[4:0], w[4:2]};
        sum = int'(r8) * int'(GRAY_R_W) + int'(g8) * int'(GRAY_G_W)
            + int'(b8) * int'(GRAY_B_W);
        return 8'(sum >> 8);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t ns: %s, got %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // wait for o_vs at a level, bounded by two frames
    task automatic wait_vs_level(input logic level);
        int n;
        n = 0;
        while (o_vs !== level) begin
            @(negedge vtc_vs_out);
            n++;
            if (n > 2 * FRAME_CYC) fail_now("timeout: o_vs never reached the expected level");
        end
    endtask

    task automatic wait_vs_rise();
        wait_vs_level(1'b0);
        wait_vs_level(1'b1);
    endtask

    // one href period of bytes, high byte first; model follows complete pairs only
    task automatic send_line(input int n_bytes, input logic vs_high);
        logic [15:0] word;
        int          b;
        word = '0;
        for (b = 0; b < n_bytes; b++) begin
            if (b % 2 == 0) word = 16'($random(seed));
            @(negedge vtc_vs_out);
            i_cam_href  = 1'b1;
            i_cam_vsync = vs_high;
            i_cam_data  = (b % 2 == 0) ? word[15:8] : word[7:0];
            if (b % 2 == 1 && !vs_high && b / 2 < H_DISP) model[b / 2] = ref_gray(word);
        end
        @(negedge vtc_vs_out);
        i_cam_href  = 1'b0;    // phase restarts here
        i_cam_vsync = 1'b0;
        i_cam_data  = 8'h00;
        repeat (2) @(negedge vtc_vs_out);
    endtask

    // wait one frame and make sure every active pixel of it was compared
    task automatic check_frame(input string what);
        int p0;
        p0 = pix_checked;
        wait_vs_rise();
        check_value(pix_checked - p0, H_DISP * V_DISP, what);
    endtask

    // raster monitor, outputs sampled on the falling edge where they are stable
    always @(negedge vtc_vs_out) begin
        if (mon_en) begin
            if (since_de >= 0) since_de++;
            if (o_de) begin
                if (!de_prev) begin    // each display line needs its hs first
                    check_value(32'(since_de < 0), 1, "hs pulse between display lines");
                end
                if (cmp_en) begin
                    check_value(32'(o_gray), 32'(model[col]), "gray at display column");
                    pix_checked++;
                end
                col++;
            end else if (de_prev) begin
                check_value(col, H_DISP, "de cycles in a line");
                line_cnt++;
                col = 0;
                since_de = 0;
            end
            if (o_hs && !hs_prev) begin    // hs follows the front porch
                if (since_de >= 0) check_value(since_de, H_FRONT, "hs start after de");
                since_de = -1;
            end
            if (o_vs && !vs_prev) begin    // new frame
                check_value(line_cnt, V_DISP, "de lines in a frame");
                line_cnt = 0;
                vs_cnt++;
            end
            check_value(32'(o_frame_led), 32'(vs_cnt[4]), "frame led");
            de_prev = o_de;
            vs_prev = o_vs;
            hs_prev = o_hs;
        end
    end

    initial begin
        seed        = 32'h9ed77f86;
        i_reset     = 1'b1;
        i_cam_href  = 1'b0;
        i_cam_vsync = 1'b0;
        i_cam_data  = 8'h00;

        // outputs quiet through reset
        repeat (5) begin
            @(negedge vtc_vs_out);
            check_value({28'd0, o_hs, o_vs, o_de, o_frame_led}, 32'd0, "outputs in reset");
        end
        i_reset = 1'b0;
        mon_en  = 1'b1;

        // no sync or led before the raster reaches them
        repeat (H_DISP + H_FRONT) begin
            @(negedge vtc_vs_out);
            check_value({29'd0, o_hs, o_vs, o_frame_led}, 32'd0, "sync or led after reset");
        end

        // full random line written in blanking, then a whole frame compared
        wait_vs_rise();
        send_line(2 * H_DISP, 1'b0);
        cmp_en = 1'b1;
        check_frame("pixels compared, full line");

        // odd byte counts, the trailing byte is lost and the next line starts clean
        send_line(11, 1'b0);
        send_line(7, 1'b0);
        check_frame("pixels compared, short lines");

        // bytes under camera vsync leave the line alone
        send_line(2 * H_DISP, 1'b1);
        check_frame("pixels compared, vsync bytes");

        // led runs through two halves of the 5-bit frame count and wraps
        while (vs_cnt < 33) begin
            wait_vs_rise();
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- compile.f
logic/video_pkg.sv
logic/cam_capture.sv
logic/gray_convert.sv
logic/line_buffer.sv
logic/video_timing.sv
logic/gray_video_top.sv
tb/gray_video_sva.sv
tb/gray_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the gray video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module gray_video_tb -o gray_video_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/gray_video_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
